/* src/rowbuf_pkg.sv */
package rowbuf_pkg;

    //////////////////////////////
    // widths and latencies
    //////////////////////////////

    localparam int PIXEL_WIDTH      = 16;
    localparam int ROW_BUF_DEPTH    = 512;
    localparam int ROW_ADDR_WIDTH   = $clog2(ROW_BUF_DEPTH);
    // top address bit picks the row half
    localparam int COL_WIDTH        = ROW_ADDR_WIDTH - 1;

    // accept register plus two RAM stages
    localparam int READ_LATENCY     = 3;
    localparam int ROW_MATRIC_DELAY = 3;

    // 3x3 window walks five steps, counting 0 to 4
    localparam int WINDOW_CYCLES    = 5;

    //////////////////////////////
    // vector types
    //////////////////////////////

    typedef logic [PIXEL_WIDTH-1:0]              pixel_t;
    typedef logic [COL_WIDTH-1:0]                col_t;
    typedef logic [ROW_ADDR_WIDTH-1:0]           row_addr_t;
    typedef logic [1:0]                          prime_row_t;
    typedef logic [1:0]                          gray_t;
    typedef logic [$clog2(WINDOW_CYCLES)-1:0]    cycle_cnt_t;

    // controller states, one-hot
    typedef enum logic [5:0] {
        ST_IDLE          = 6'b000001,
        ST_PRIME_BUFFER  = 6'b000010,
        ST_WAIT_PFB_LOAD = 6'b000100,
        ST_ACTIVE        = 6'b001000,
        ST_WAIT_JOB_DONE = 6'b010000,
        ST_SEND_COMPLETE = 6'b100000
    } awe_state_t;

    //////////////////////////////
    // grouped signals
    //////////////////////////////

    // sequence word, parity at the top
    typedef struct packed {
        logic                 parity;
        logic                 half;
        col_t                 even_col;
        logic [COL_WIDTH-2:0] odd_col_hi;
        logic                 odd_col_lo;
    } pix_seq_t;

    typedef struct packed {
        pixel_t odd;
        pixel_t even;
    } pixel_pair_t;

    typedef struct packed {
        logic      en;
        row_addr_t addr;
        pixel_t    data;
    } ram_write_t;

    typedef struct packed {
        logic      en;
        row_addr_t even_addr;
        row_addr_t odd_addr;
    } ram_read_t;

endpackage

/* src/rowbuf_ram.sv */
`timescale 1ns/1ps

module rowbuf_ram (
    input  logic                   clk,
    input  rowbuf_pkg::ram_write_t wr,
    input  logic                   rd_en,
    input  rowbuf_pkg::row_addr_t  rd_addr,
    output rowbuf_pkg::pixel_t     dout
);

    rowbuf_pkg::pixel_t mem [rowbuf_pkg::ROW_BUF_DEPTH];
    rowbuf_pkg::pixel_t rd_q;

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // array read, read-first against a write in the same cycle
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    // output register, holds while no read is issued
    always_ff @(posedge clk) begin
        dout <= rd_q;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    a_wr_addr_range : assert property (
        @(posedge clk) wr.en |-> (!$isunknown(wr.addr)
            && int'(wr.addr) < rowbuf_pkg::ROW_BUF_DEPTH)
    ) else $error("row buffer write address out of range: %h", wr.addr);

endmodule

/* src/rowbuf_bank.sv */
`timescale 1ns/1ps

module rowbuf_bank (
    input  logic                    clk,
    input  rowbuf_pkg::ram_write_t  wr_even,
    input  rowbuf_pkg::ram_write_t  wr_odd,
    input  rowbuf_pkg::ram_read_t   rd,
    output rowbuf_pkg::pixel_pair_t dout
);

    rowbuf_pkg::pixel_t even_dout;
    rowbuf_pkg::pixel_t odd_dout;

    //////////////////////////////
    // even and odd buffers
    //////////////////////////////

    // one read request drives both RAMs
    // with separate addresses
    rowbuf_ram u_even (
        .clk     (clk),
        .wr      (wr_even),
        .rd_en   (rd.en),
        .rd_addr (rd.even_addr),
        .dout    (even_dout)
    );

    rowbuf_ram u_odd (
        .clk     (clk),
        .wr      (wr_odd),
        .rd_en   (rd.en),
        .rd_addr (rd.odd_addr),
        .dout    (odd_dout)
    );

    // odd pixel above even pixel
    assign dout.odd  = odd_dout;
    assign dout.even = even_dout;

endmodule

/* src/row_write_ctrl.sv */
`timescale 1ns/1ps

module row_write_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  rowbuf_pkg::awe_state_t state,
    input  rowbuf_pkg::gray_t      gray_code,
    input  rowbuf_pkg::col_t       num_input_cols,
    input  logic                   pfb_rden,
    input  rowbuf_pkg::prime_row_t input_row,
    input  rowbuf_pkg::col_t       input_col,
    input  rowbuf_pkg::pixel_t     pixel_datain,
    input  logic                   row_matric,
    input  logic                   last_kernel,
    input  logic                   move_one_row_down,
    input  rowbuf_pkg::col_t       row_matric_addr,
    output rowbuf_pkg::ram_write_t wr_even,
    output rowbuf_pkg::ram_write_t wr_odd
);

    typedef struct packed {
        logic               valid;
        rowbuf_pkg::col_t   col;
        rowbuf_pkg::pixel_t data;
    } matric_req_t;

    localparam int LAST = rowbuf_pkg::ROW_MATRIC_DELAY - 1;

    matric_req_t            matric_pipe [rowbuf_pkg::ROW_MATRIC_DELAY];
    logic                   prime_ok;
    logic                   matric_ok;
    logic                   pipe_busy;
    rowbuf_pkg::ram_write_t nxt_even;
    rowbuf_pkg::ram_write_t nxt_odd;

    assign prime_ok  = (state == rowbuf_pkg::ST_PRIME_BUFFER) && pfb_rden
                       && (input_col <= num_input_cols);
    assign matric_ok = row_matric && (last_kernel || move_one_row_down)
                       && (row_matric_addr <= num_input_cols);

    //////////////////////////////
    // matriculation delay line
    //////////////////////////////

    // pixel travels with its request
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rowbuf_pkg::ROW_MATRIC_DELAY; i++) begin
                matric_pipe[i].valid <= 1'b0;
            end
        end else begin
            matric_pipe[0] <= '{valid: matric_ok, col: row_matric_addr, data: pixel_datain};
            for (int i = 1; i < rowbuf_pkg::ROW_MATRIC_DELAY; i++) begin
                matric_pipe[i] <= matric_pipe[i-1];
            end
        end
    end

    always_comb begin
        pipe_busy = 1'b0;
        for (int i = 0; i < rowbuf_pkg::ROW_MATRIC_DELAY; i++) begin
            pipe_busy = pipe_busy | matric_pipe[i].valid;
        end
    end

    //////////////////////////////
    // write steering
    //////////////////////////////

    always_comb begin
        nxt_even = '{en: 1'b0, addr: {1'b0, input_col}, data: pixel_datain};
        nxt_odd  = '{en: 1'b0, addr: {1'b0, input_col}, data: pixel_datain};

        // priming: row 0 to both lower halves, rows 1 and 2 to upper halves
        if (prime_ok) begin
            case (input_row)
                2'd0: begin
                    nxt_even.en = 1'b1;
                    nxt_odd.en  = 1'b1;
                end
                2'd1: begin
                    nxt_odd.en   = 1'b1;
                    nxt_odd.addr = {1'b1, input_col};
                end
                2'd2: begin
                    nxt_even.en   = 1'b1;
                    nxt_even.addr = {1'b1, input_col};
                end
                default: begin
                end
            endcase
        end

        // incoming row overrides priming on the same RAM
        if (matric_pipe[LAST].valid) begin
            if (^gray_code) begin
                nxt_even = '{en: 1'b1, addr: {gray_code[1], matric_pipe[LAST].col},
                             data: matric_pipe[LAST].data};
            end else begin
                nxt_odd  = '{en: 1'b1, addr: {gray_code[0], matric_pipe[LAST].col},
                             data: matric_pipe[LAST].data};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_even.en <= 1'b0;
            wr_odd.en  <= 1'b0;
        end else begin
            wr_even <= nxt_even;
            wr_odd  <= nxt_odd;
        end
    end

    // idle with nothing in flight must leave the buffer alone
    a_idle_no_write : assert property (
        @(posedge clk) disable iff (rst)
        (state == rowbuf_pkg::ST_IDLE && !pipe_busy) |=> (!wr_even.en && !wr_odd.en)
    ) else $error("row buffer written while idle");

endmodule

/* src/window_read_ctrl.sv */
`timescale 1ns/1ps

module window_read_ctrl (
    input  logic                    clk,
    input  logic                    rst,
    input  rowbuf_pkg::awe_state_t  state,
    input  rowbuf_pkg::gray_t       gray_code,
    input  logic                    execute,
    input  logic                    move_one_row_down,
    input  rowbuf_pkg::pix_seq_t    pix_seq_datain,
    input  rowbuf_pkg::pixel_pair_t bank_dout,
    output rowbuf_pkg::ram_read_t   rd,
    output rowbuf_pkg::pixel_pair_t pixel_dataout,
    output logic                    pixel_valid,
    output rowbuf_pkg::cycle_cnt_t  cycle_counter
);

    localparam int LAT = rowbuf_pkg::READ_LATENCY;

    logic                  accept;
    rowbuf_pkg::row_addr_t even_addr;
    rowbuf_pkg::row_addr_t odd_addr;
    logic                  rd_en_q;
    rowbuf_pkg::row_addr_t even_addr_q;
    rowbuf_pkg::row_addr_t odd_addr_q;
    logic [LAT-1:0]        valid_sr;
    logic [LAT-1:0]        step_sr;
    logic                  step;

    //////////////////////////////
    // sequence word decode
    //////////////////////////////

    assign accept = (state == rowbuf_pkg::ST_ACTIVE) && execute;

    // half select rotated by the gray code
    assign even_addr = {pix_seq_datain.half ^ gray_code[1], pix_seq_datain.even_col};
    assign odd_addr  = {pix_seq_datain.half ^ gray_code[0], pix_seq_datain.odd_col_hi,
                        pix_seq_datain.odd_col_lo | pix_seq_datain.parity};

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_en_q <= 1'b0;
        end else begin
            rd_en_q <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            even_addr_q <= even_addr;
            odd_addr_q  <= odd_addr;
        end
    end

    assign rd = '{en: rd_en_q, even_addr: even_addr_q, odd_addr: odd_addr_q};

    //////////////////////////////
    // valid, step and counter
    //////////////////////////////

    // flags line up with data leaving the bank
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
            step_sr  <= '0;
        end else begin
            valid_sr <= {valid_sr[LAT-2:0], accept & ~move_one_row_down};
            step_sr  <= {step_sr[LAT-2:0], accept & move_one_row_down};
        end
    end

    assign pixel_valid   = valid_sr[LAT-1];
    assign step          = step_sr[LAT-1];
    assign pixel_dataout = bank_dout;

    // window step count, cleared on any gap
    always_ff @(posedge clk) begin
        if (rst) begin
            cycle_counter <= '0;
        end else if (pixel_valid || step) begin
            if (cycle_counter == rowbuf_pkg::cycle_cnt_t'(rowbuf_pkg::WINDOW_CYCLES - 1)) begin
                cycle_counter <= '0;
            end else begin
                cycle_counter <= cycle_counter + rowbuf_pkg::cycle_cnt_t'(1);
            end
        end else begin
            cycle_counter <= '0;
        end
    end

    a_valid_step_excl : assert property (
        @(posedge clk) disable iff (rst) !(pixel_valid && step)
    ) else $error("pixel_valid and step pulse high together");

    a_counter_range : assert property (
        @(posedge clk) disable iff (rst)
        cycle_counter <= rowbuf_pkg::cycle_cnt_t'(rowbuf_pkg::WINDOW_CYCLES - 1)
    ) else $error("cycle_counter out of range: %0d", cycle_counter);

endmodule

/* src/rowbuf_top.sv */
`timescale 1ns/1ps

module rowbuf_top (
    input  logic                    clk,
    input  logic                    rst,
    input  rowbuf_pkg::awe_state_t  state,
    input  rowbuf_pkg::gray_t       gray_code,
    input  rowbuf_pkg::col_t        num_input_cols,
    input  logic                    pfb_rden,
    input  rowbuf_pkg::prime_row_t  input_row,
    input  rowbuf_pkg::col_t        input_col,
    input  rowbuf_pkg::pixel_t      pixel_datain,
    input  logic                    execute,
    input  rowbuf_pkg::pix_seq_t    pix_seq_datain,
    input  logic                    move_one_row_down,
    input  logic                    row_matric,
    input  logic                    last_kernel,
    input  rowbuf_pkg::col_t        row_matric_addr,
    output rowbuf_pkg::pixel_pair_t pixel_dataout,
    output logic                    pixel_valid,
    output rowbuf_pkg::cycle_cnt_t  cycle_counter
);

    rowbuf_pkg::ram_write_t  wr_even;
    rowbuf_pkg::ram_write_t  wr_odd;
    rowbuf_pkg::ram_read_t   rd;
    rowbuf_pkg::pixel_pair_t bank_dout;

    //////////////////////////////
    // producer, buffer, consumer
    //////////////////////////////

    row_write_ctrl u_wr (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .gray_code         (gray_code),
        .num_input_cols    (num_input_cols),
        .pfb_rden          (pfb_rden),
        .input_row         (input_row),
        .input_col         (input_col),
        .pixel_datain      (pixel_datain),
        .row_matric        (row_matric),
        .last_kernel       (last_kernel),
        .move_one_row_down (move_one_row_down),
        .row_matric_addr   (row_matric_addr),
        .wr_even           (wr_even),
        .wr_odd            (wr_odd)
    );

    rowbuf_bank u_bank (
        .clk     (clk),
        .wr_even (wr_even),
        .wr_odd  (wr_odd),
        .rd      (rd),
        .dout    (bank_dout)
    );

    window_read_ctrl u_rd (
        .clk               (clk),
        .rst               (rst),
        .state             (state),
        .gray_code         (gray_code),
        .execute           (execute),
        .move_one_row_down (move_one_row_down),
        .pix_seq_datain    (pix_seq_datain),
        .bank_dout         (bank_dout),
        .rd                (rd),
        .pixel_dataout     (pixel_dataout),
        .pixel_valid       (pixel_valid),
        .cycle_counter     (cycle_counter)
    );

endmodule

/* bench/rowbuf_checker.sv */
`timescale 1ns/1ps

module rowbuf_checker (
    input  logic                    clk,
    input  logic                    rst,
    input  rowbuf_pkg::awe_state_t  state,
    input  rowbuf_pkg::gray_t       gray_code,
    input  rowbuf_pkg::col_t        num_input_cols,
    input  logic                    pfb_rden,
    input  rowbuf_pkg::prime_row_t  input_row,
    input  rowbuf_pkg::col_t        input_col,
    input  rowbuf_pkg::pixel_t      pixel_datain,
    input  logic                    execute,
    input  rowbuf_pkg::pix_seq_t    pix_seq_datain,
    input  logic                    move_one_row_down,
    input  logic                    row_matric,
    input  logic                    last_kernel,
    input  rowbuf_pkg::col_t        row_matric_addr,
    input  rowbuf_pkg::pixel_pair_t pixel_dataout,
    input  logic                    pixel_valid,
    input  rowbuf_pkg::cycle_cnt_t  cycle_counter,
    output int                      err_count,
    output int                      check_count
);

    localparam int RING = 8;
    localparam int D    = rowbuf_pkg::ROW_MATRIC_DELAY;

    rowbuf_pkg::pixel_t      mem_even [rowbuf_pkg::ROW_BUF_DEPTH];
    rowbuf_pkg::pixel_t      mem_odd  [rowbuf_pkg::ROW_BUF_DEPTH];

    // reads in flight indexed by accept cycle
    logic                    ring_acc       [RING];
    logic                    ring_move      [RING];
    rowbuf_pkg::row_addr_t   ring_even_addr [RING];
    rowbuf_pkg::row_addr_t   ring_odd_addr  [RING];
    rowbuf_pkg::pixel_pair_t ring_data      [RING];

    // incoming row requests in flight
    logic                    mp_valid [D];
    rowbuf_pkg::col_t        mp_col   [D];
    rowbuf_pkg::pixel_t      mp_data  [D];

    rowbuf_pkg::ram_write_t  pend_even;
    rowbuf_pkg::ram_write_t  pend_odd;
    rowbuf_pkg::cycle_cnt_t  cnt_exp;
    int                      cyc;
    logic                    started;
    int                      ia;
    int                      ib;
    int                      ic;
    logic                    v_exp;
    logic                    s_exp;

    initial begin
        err_count   = 0;
        check_count = 0;
        cyc         = RING;
        started     = 1'b0;
        cnt_exp     = '0;
        pend_even   = '0;
        pend_odd    = '0;
        for (int i = 0; i < RING; i++) begin
            ring_acc[i] = 1'b0;
        end
        for (int i = 0; i < D; i++) begin
            mp_valid[i] = 1'b0;
        end
    end

    task automatic report(input string name, input logic [31:0] exp, input logic [31:0] got);
        err_count++;
        $display("** Error: %s expected %h got %h at %0t", name, exp, got, $time);
    endtask

    // each RAM holds two row halves of half the depth
    function automatic rowbuf_pkg::row_addr_t half_col_addr(input logic half_bit,
                                                           input rowbuf_pkg::col_t col);
        return rowbuf_pkg::row_addr_t'(int'(half_bit) * (rowbuf_pkg::ROW_BUF_DEPTH / 2)
                                       + int'(col));
    endfunction

    always @(posedge clk) begin
        ia = (cyc - rowbuf_pkg::READ_LATENCY) % RING;
        ib = (cyc - 1) % RING;
        ic = cyc % RING;
        v_exp = ring_acc[ia] && !ring_move[ia];
        s_exp = ring_acc[ia] && ring_move[ia];

        //////////////////////////////
        // compare outputs
        //////////////////////////////
        if (started) begin
            check_count++;
            if (pixel_valid !== v_exp) begin
                report("pixel_valid", 32'(v_exp), 32'(pixel_valid));
            end
            if (cycle_counter !== cnt_exp) begin
                report("cycle_counter", 32'(cnt_exp), 32'(cycle_counter));
            end
            if (v_exp && pixel_dataout !== ring_data[ia]) begin
                report("pixel_dataout", 32'(ring_data[ia]), 32'(pixel_dataout));
            end
        end
        started = started | rst;

        // window counter counts on valid or step and clears on a gap
        if (rst) begin
            cnt_exp = '0;
        end else if (v_exp || s_exp) begin
            cnt_exp = rowbuf_pkg::cycle_cnt_t'((int'(cnt_exp) + 1)
                                               % rowbuf_pkg::WINDOW_CYCLES);
        end else begin
            cnt_exp = '0;
        end
        ring_acc[ia] = 1'b0;

        // read issued last cycle sees memory before this edge's writes
        if (ring_acc[ib]) begin
            ring_data[ib] = {mem_odd[ring_odd_addr[ib]], mem_even[ring_even_addr[ib]]};
        end

        if (pend_even.en) begin
            mem_even[pend_even.addr] = pend_even.data;
        end
        if (pend_odd.en) begin
            mem_odd[pend_odd.addr] = pend_odd.data;
        end

        //////////////////////////////
        // new requests
        //////////////////////////////
        if (rst) begin
            for (int i = 0; i < RING; i++) begin
                ring_acc[i] = 1'b0;
            end
            for (int i = 0; i < D; i++) begin
                mp_valid[i] = 1'b0;
            end
            pend_even = '0;
            pend_odd  = '0;
        end else begin
            pend_even = '0;
            pend_odd  = '0;
            if (state == rowbuf_pkg::ST_PRIME_BUFFER && pfb_rden
                && input_col <= num_input_cols) begin
                if (input_row == 2'd0) begin
                    pend_even = '{en: 1'b1, addr: half_col_addr(1'b0, input_col),
                                  data: pixel_datain};
                    pend_odd  = '{en: 1'b1, addr: half_col_addr(1'b0, input_col),
                                  data: pixel_datain};
                end else if (input_row == 2'd1) begin
                    pend_odd  = '{en: 1'b1, addr: half_col_addr(1'b1, input_col),
                                  data: pixel_datain};
                end else if (input_row == 2'd2) begin
                    pend_even = '{en: 1'b1, addr: half_col_addr(1'b1, input_col),
                                  data: pixel_datain};
                end
            end
            // incoming row steered by gray parity wins over priming
            if (mp_valid[D-1]) begin
                if (gray_code[1] ^ gray_code[0]) begin
                    pend_even = '{en: 1'b1, addr: half_col_addr(gray_code[1], mp_col[D-1]),
                                  data: mp_data[D-1]};
                end else begin
                    pend_odd  = '{en: 1'b1, addr: half_col_addr(gray_code[0], mp_col[D-1]),
                                  data: mp_data[D-1]};
                end
            end
            for (int i = D - 1; i > 0; i--) begin
                mp_valid[i] = mp_valid[i-1];
                mp_col[i]   = mp_col[i-1];
                mp_data[i]  = mp_data[i-1];
            end
            mp_valid[0] = row_matric && (last_kernel || move_one_row_down)
                          && row_matric_addr <= num_input_cols;
            mp_col[0]   = row_matric_addr;
            mp_data[0]  = pixel_datain;

            ring_acc[ic]       = (state == rowbuf_pkg::ST_ACTIVE) && execute;
            ring_move[ic]      = move_one_row_down;
            ring_even_addr[ic] = half_col_addr(pix_seq_datain.half ^ gray_code[1],
                                               pix_seq_datain.even_col);
            ring_odd_addr[ic]  = half_col_addr(pix_seq_datain.half ^ gray_code[0],
                                               {pix_seq_datain.odd_col_hi,
                                                pix_seq_datain.odd_col_lo
                                                | pix_seq_datain.parity});
        end
        cyc++;
    end

endmodule

/* bench/tb_rowbuf.sv */
`timescale 1ns/1ps

module tb_rowbuf;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 3;
    localparam int PRIME_FULL   = 3 * 256;
    localparam int PRIME_RAND   = 4 * 64;
    localparam int DECODE_LEN   = 300;
    localparam int MATRIC_LEN   = 4 * 40;
    localparam int COUNTER_LEN  = 300;
    localparam int RESET_PHASE  = 4 + RESET_CYCLES + 200;
    localparam int SWEEP_LEN    = 512;
    localparam int DRAIN_LEN    = 10;
    localparam int TOTAL_CYCLES = RESET_CYCLES + PRIME_FULL + PRIME_RAND + DECODE_LEN
                                  + MATRIC_LEN + COUNTER_LEN + RESET_PHASE + SWEEP_LEN
                                  + DRAIN_LEN;

    logic                    clk;
    logic                    rst;
    rowbuf_pkg::awe_state_t  state;
    rowbuf_pkg::gray_t       gray_code;
    rowbuf_pkg::col_t        num_input_cols;
    logic                    pfb_rden;
    rowbuf_pkg::prime_row_t  input_row;
    rowbuf_pkg::col_t        input_col;
    rowbuf_pkg::pixel_t      pixel_datain;
    logic                    execute;
    rowbuf_pkg::pix_seq_t    pix_seq_datain;
    logic                    move_one_row_down;
    logic                    row_matric;
    logic                    last_kernel;
    rowbuf_pkg::col_t        row_matric_addr;
    rowbuf_pkg::pixel_pair_t pixel_dataout;
    logic                    pixel_valid;
    rowbuf_pkg::cycle_cnt_t  cycle_counter;
    int                      err_count;
    int                      check_count;
    logic [31:0]             rng_state;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rowbuf_top u_dut (.*);

    rowbuf_checker u_chk (.*);

    function automatic logic [31:0] rand_word();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // random read request with move only when allowed
    task automatic drive_read(input logic allow_move);
        logic [31:0] r;
        r = rand_word();
        execute           = r[0] | r[1];
        move_one_row_down = allow_move & r[2] & r[3];
        r = rand_word();
        pix_seq_datain    = rowbuf_pkg::pix_seq_t'(r[17:0]);
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        logic [31:0] r;
        rng_state = 32'd28557;
        clk = 1'b0;
        rst = 1'b1;
        state = rowbuf_pkg::ST_IDLE;
        gray_code = 2'd0;
        num_input_cols = 8'hff;
        pfb_rden = 1'b0;
        input_row = 2'd0;
        input_col = 8'd0;
        pixel_datain = 16'd0;
        execute = 1'b0;
        pix_seq_datain = '0;
        move_one_row_down = 1'b0;
        row_matric = 1'b0;
        last_kernel = 1'b0;
        row_matric_addr = 8'd0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        // fill every row half once
        state = rowbuf_pkg::ST_PRIME_BUFFER;
        pfb_rden = 1'b1;
        for (int i = 0; i < PRIME_FULL; i++) begin
            r = rand_word();
            input_row = 2'(i / 256);
            input_col = 8'(i % 256);
            pixel_datain = r[15:0];
            next_cycle();
        end

        // random column counts with some columns out of range and row 3 ignored
        for (int row = 0; row < 4; row++) begin
            r = rand_word();
            num_input_cols = r[7:0];
            input_row = 2'(row);
            for (int i = 0; i < PRIME_RAND / 4; i++) begin
                r = rand_word();
                pfb_rden = r[0] | r[1];
                input_col = r[15:8];
                pixel_datain = r[31:16];
                next_cycle();
            end
        end
        pfb_rden = 1'b0;
        num_input_cols = 8'd200;

        // decode with a fresh gray code every cycle
        state = rowbuf_pkg::ST_ACTIVE;
        for (int i = 0; i < DECODE_LEN; i++) begin
            r = rand_word();
            gray_code = r[1:0];
            drive_read(1'b0);
            next_cycle();
        end

        // incoming rows at each gray code with a quiet tail before it changes
        for (int g = 0; g < 4; g++) begin
            gray_code = 2'(g);
            for (int i = 0; i < MATRIC_LEN / 4; i++) begin
                r = rand_word();
                state = r[0] ? rowbuf_pkg::ST_ACTIVE : rowbuf_pkg::ST_PRIME_BUFFER;
                pfb_rden = r[1];
                input_row = r[3:2];
                input_col = r[11:4];
                row_matric = (i < 32) & r[12];
                last_kernel = r[13];
                row_matric_addr = r[21:14];
                pixel_datain = {r[31:22], r[5:0]};
                drive_read(1'b1);
                next_cycle();
            end
        end
        row_matric = 1'b0;
        pfb_rden = 1'b0;
        state = rowbuf_pkg::ST_ACTIVE;

        // counter with gaps and move reads
        for (int i = 0; i < COUNTER_LEN; i++) begin
            drive_read(1'b1);
            next_cycle();
        end

        // reset with incoming rows pending
        for (int i = 0; i < 4; i++) begin
            r = rand_word();
            row_matric = 1'b1;
            last_kernel = 1'b1;
            row_matric_addr = 8'(r[7:0] % 201);
            pixel_datain = r[31:16];
            drive_read(1'b1);
            next_cycle();
        end
        row_matric = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) next_cycle();
        rst = 1'b0;
        for (int i = 0; i < 200; i++) begin
            drive_read(1'b1);
            next_cycle();
        end

        // read back every address
        gray_code = 2'd0;
        move_one_row_down = 1'b0;
        execute = 1'b1;
        for (int i = 0; i < SWEEP_LEN; i++) begin
            pix_seq_datain = rowbuf_pkg::pix_seq_t'({1'b0, 1'(i / 256), 8'(i), 8'(i)});
            next_cycle();
        end
        execute = 1'b0;
        repeat (DRAIN_LEN) next_cycle();

        $display("errors: %0d in %0d checked cycles", err_count, check_count);
        if (err_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((TOTAL_CYCLES + 100) * CLK_PERIOD);
        $display("timeout: stimulus did not complete in %0d cycles", TOTAL_CYCLES + 100);
        $display("errors: %0d in %0d checked cycles", err_count, check_count);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* flist.f */
src/rowbuf_pkg.sv
src/rowbuf_ram.sv
src/rowbuf_bank.sv
src/row_write_ctrl.sv
src/window_read_ctrl.sv
src/rowbuf_top.sv
bench/rowbuf_checker.sv
bench/tb_rowbuf.sv

/* Makefile */
SOURCES := $(wildcard src/*.sv bench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_rowbuf: flist.f $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module tb_rowbuf -f flist.f -o Vtb_rowbuf

run: obj_dir/Vtb_rowbuf
	./obj_dir/Vtb_rowbuf > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
